// ==== Bender.yml ====
package:
  name: dsp_slice

sources:
  - include_dirs:
      - design
    files:
      - design/dsp_pkg.sv
      - design/dsp_operand_stage.sv
      - design/dsp_item_fifo.sv
      - design/dsp_alu_stage.sv
      - design/dsp_slice_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/dsp_slice_checker.sv
      - verif/dsp_slice_tb.sv

// ==== design/dsp_alu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dsp_defs.svh"

module dsp_alu_stage (
    input  logic                 w_CLK,
    input  logic                 RSTALLCARRYIN,
    input  logic                 pop_valid,
    input  dsp_pkg::dsp_item_t   pop_item,
    output logic                 pop_ready,
    output logic                 res_valid,
    output dsp_pkg::dsp_result_t res,
    input  logic                 res_ready
);
    import dsp_pkg::*;

    // Two guard bits so three operands plus carry never wrap
    localparam int SUM_W = `DSP_P_W + 2;

    logic [`DSP_P_W-1:0] x_opnd;
    logic [`DSP_P_W-1:0] y_opnd;
    logic [`DSP_P_W-1:0] z_opnd;

    logic [SUM_W-1:0]    xy_sum;
    logic [SUM_W-1:0]    add_sum;
    logic [`DSP_P_W-1:0] alu_p;
    logic                alu_cout;

    logic                pdet;
    logic                pdetb;
    logic                no_det;
    logic                load;

    // Take a new item when P is empty or its result leaves this cycle
    assign pop_ready = ~res_valid | res_ready;
    assign load      = pop_valid & pop_ready;

    // X, Y and Z multiplexers
    always_comb begin
        case (pop_item.ctrl.x_sel)
            X_ZERO:  x_opnd = '0;
            X_MULT:  x_opnd = pop_item.mult;
            X_P:     x_opnd = res.p;
            X_AB:    x_opnd = pop_item.ab;
            default: x_opnd = '0;
        endcase

        case (pop_item.ctrl.y_sel)
            Y_ZERO:  y_opnd = '0;
            Y_C:     y_opnd = pop_item.c;
            Y_ONES:  y_opnd = '1;
            default: y_opnd = '0;
        endcase

        case (pop_item.ctrl.z_sel)
            Z_ZERO:    z_opnd = '0;
            Z_P:       z_opnd = res.p;
            Z_C:       z_opnd = pop_item.c;
            // Arithmetic shift keeps the sign of P
            Z_P_SHIFT: z_opnd = $signed(res.p) >>> `DSP_SHIFT;
            default:   z_opnd = '0;
        endcase
    end

    // Three-input adder
    assign xy_sum  = SUM_W'(x_opnd) + SUM_W'(y_opnd) + SUM_W'(pop_item.ctrl.carry_in);
    assign add_sum = xy_sum + SUM_W'(z_opnd);

    always_comb begin
        case (pop_item.ctrl.alu_op)
            ALU_SUB: begin
                alu_p    = z_opnd - xy_sum[`DSP_P_W-1:0];
                // No borrow out of the subtract
                alu_cout = (SUM_W'(z_opnd) >= xy_sum);
            end
            default: begin
                alu_p    = add_sum[`DSP_P_W-1:0];
                alu_cout = add_sum[`DSP_P_W];
            end
        endcase
    end

    // Pattern detect on the new P, masked bits always match
    assign pdet   = &(~(`DSP_PATTERN ^ alu_p) | `DSP_MASK);
    assign pdetb  = &((`DSP_PATTERN ^ alu_p) | `DSP_MASK);
    assign no_det = ~pdet & ~pdetb;

    // P register, also the accumulator feedback.
    // The detect flags still in res belong to the previous result
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            res_valid <= 1'b0;
            res       <= '0;
        end else if (load) begin
            res_valid            <= 1'b1;
            res.p                <= alu_p;
            res.carry_out        <= alu_cout;
            res.pattern_detect   <= pdet;
            res.pattern_b_detect <= pdetb;
            res.overflow         <= res.pattern_detect & no_det;
            res.underflow        <= res.pattern_b_detect & no_det;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/dsp_defs.svh ====
`ifndef DSP_DEFS_SVH
`define DSP_DEFS_SVH

// Operand widths
`define DSP_A_W        30
`define DSP_B_W        18

// Low bits of A that go into the multiplier
`define DSP_MULT_A_W   27

// Width of C, P and the ALU datapath
`define DSP_P_W        48

// Right shift applied to P for the shifted feedback operand
`define DSP_SHIFT      17

// Entries in the product buffer between producer and consumer
`define DSP_FIFO_DEPTH 4

// Pattern detector constants
// Set mask bits are ignored, so only bits 47 and 46 take part
`define DSP_PATTERN    48'h0000_0000_0000
`define DSP_MASK       48'h3FFF_FFFF_FFFF

`endif

// ==== design/dsp_item_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dsp_defs.svh"

module dsp_item_fifo (
    input  logic               w_CLK,
    input  logic               RSTALLCARRYIN,
    input  logic               push_valid,
    input  dsp_pkg::dsp_item_t push_item,
    output logic               push_ready,
    output logic               pop_valid,
    output dsp_pkg::dsp_item_t pop_item,
    input  logic               pop_ready
);
    import dsp_pkg::*;

    localparam int DEPTH = `DSP_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dsp_item_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // Full refuses the push even when a pop happens in the same cycle
    assign push_ready = (count != CNT_W'(DEPTH));
    assign pop_valid  = (count != '0);

    assign do_push = push_valid & push_ready;
    assign do_pop  = pop_valid & pop_ready;

    assign pop_item = mem[rd_ptr];

    always_ff @(posedge w_CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // Pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/dsp_operand_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dsp_defs.svh"

module dsp_operand_stage (
    input  logic               w_CLK,
    input  logic               RSTALLCARRYIN,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  dsp_pkg::dsp_op_t   wb_op,
    output logic               wb_ack,
    output logic               push_valid,
    output dsp_pkg::dsp_item_t push_item,
    input  logic               push_ready
);
    import dsp_pkg::*;

    localparam int PROD_W = `DSP_MULT_A_W + `DSP_B_W;
    localparam int EXT_W  = `DSP_P_W - PROD_W;

    // Input register with the acknowledged operation
    dsp_op_t in_op;
    logic    in_valid;

    logic    prod_advance;
    logic    in_free;

    logic signed [`DSP_MULT_A_W-1:0] mult_a;
    logic signed [`DSP_B_W-1:0]      mult_b;
    logic signed [PROD_W-1:0]        mult_full;

    // Product register moves when it is empty or the FIFO takes it
    assign prod_advance = ~push_valid | push_ready;

    // Input register is free now or empties at this edge
    assign in_free = ~in_valid | prod_advance;

    // Wishbone classic write, ack one cycle after the strobe is seen.
    // The ack is never raised in back-to-back cycles, so a held strobe
    // gets a single ack
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc & wb_stb & ~wb_ack & in_free;
        end
    end

    // Capture at the edge that ends the ack cycle
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            in_valid <= 1'b0;
        end else if (wb_ack) begin
            in_valid <= 1'b1;
        end else if (prod_advance) begin
            in_valid <= 1'b0;
        end
    end

    always_ff @(posedge w_CLK) begin
        if (wb_ack) begin
            in_op <= wb_op;
        end
    end

    // Signed 27 x 18 multiplier
    assign mult_a    = in_op.a[`DSP_MULT_A_W-1:0];
    assign mult_b    = in_op.b;
    assign mult_full = mult_a * mult_b;

    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            push_valid <= 1'b0;
        end else if (prod_advance) begin
            push_valid <= in_valid;
        end
    end

    // Product register payload
    always_ff @(posedge w_CLK) begin
        if (prod_advance && in_valid) begin
            push_item.mult <= {{EXT_W{mult_full[PROD_W-1]}}, mult_full};
            push_item.ab   <= {in_op.a, in_op.b};
            push_item.c    <= in_op.c;
            push_item.ctrl <= in_op.ctrl;
        end
    end

endmodule

`default_nettype wire

// ==== design/dsp_pkg.sv ====
`default_nettype none

`include "dsp_defs.svh"

package dsp_pkg;

    // X operand select
    typedef enum logic [1:0] {
        X_ZERO = 2'd0,
        X_MULT = 2'd1,
        X_P    = 2'd2,
        X_AB   = 2'd3
    } dsp_x_sel_e;

    // Y operand select, the last code is unused
    typedef enum logic [1:0] {
        Y_ZERO = 2'd0,
        Y_C    = 2'd1,
        Y_ONES = 2'd2
    } dsp_y_sel_e;

    // Z operand select
    typedef enum logic [1:0] {
        Z_ZERO    = 2'd0,
        Z_P       = 2'd1,
        Z_C       = 2'd2,
        Z_P_SHIFT = 2'd3
    } dsp_z_sel_e;

    // Sub means Z - (X + Y + carry_in)
    typedef enum logic [0:0] {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } dsp_alu_op_e;

    typedef struct packed {
        dsp_x_sel_e  x_sel;
        dsp_y_sel_e  y_sel;
        dsp_z_sel_e  z_sel;
        dsp_alu_op_e alu_op;
        logic        carry_in;
    } dsp_ctrl_t;

    // One operation as written by the host
    typedef struct packed {
        logic [`DSP_A_W-1:0] a;
        logic [`DSP_B_W-1:0] b;
        logic [`DSP_P_W-1:0] c;
        dsp_ctrl_t           ctrl;
    } dsp_op_t;

    // Operation after the multiplier stage
    typedef struct packed {
        logic [`DSP_P_W-1:0] mult;
        logic [`DSP_P_W-1:0] ab;
        logic [`DSP_P_W-1:0] c;
        dsp_ctrl_t           ctrl;
    } dsp_item_t;

    typedef struct packed {
        logic [`DSP_P_W-1:0] p;
        logic                carry_out;
        logic                pattern_detect;
        logic                pattern_b_detect;
        logic                overflow;
        logic                underflow;
    } dsp_result_t;

endpackage

`default_nettype wire

// ==== design/dsp_slice_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_slice_top (
    input  logic                 w_CLK,
    input  logic                 RSTALLCARRYIN,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  dsp_pkg::dsp_op_t     wb_op,
    output logic                 wb_ack,
    output logic                 res_valid,
    output dsp_pkg::dsp_result_t res,
    input  logic                 res_ready
);
    import dsp_pkg::*;

    // Producer to buffer
    logic      push_valid;
    logic      push_ready;
    dsp_item_t push_item;

    // Buffer to consumer
    logic      pop_valid;
    logic      pop_ready;
    dsp_item_t pop_item;

    dsp_operand_stage u_operand_stage (
        .w_CLK         (w_CLK),
        .RSTALLCARRYIN (RSTALLCARRYIN),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_op         (wb_op),
        .wb_ack        (wb_ack),
        .push_valid    (push_valid),
        .push_item     (push_item),
        .push_ready    (push_ready)
    );

    dsp_item_fifo u_item_fifo (
        .w_CLK         (w_CLK),
        .RSTALLCARRYIN (RSTALLCARRYIN),
        .push_valid    (push_valid),
        .push_item     (push_item),
        .push_ready    (push_ready),
        .pop_valid     (pop_valid),
        .pop_item      (pop_item),
        .pop_ready     (pop_ready)
    );

    dsp_alu_stage u_alu_stage (
        .w_CLK         (w_CLK),
        .RSTALLCARRYIN (RSTALLCARRYIN),
        .pop_valid     (pop_valid),
        .pop_item      (pop_item),
        .pop_ready     (pop_ready),
        .res_valid     (res_valid),
        .res           (res),
        .res_ready     (res_ready)
    );

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/dsp_pkg.sv
design/dsp_operand_stage.sv
design/dsp_item_fifo.sv
design/dsp_alu_stage.sv
design/dsp_slice_top.sv
verif/dsp_slice_checker.sv
verif/dsp_slice_tb.sv

// ==== verif/dsp_slice_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_slice_checker (
    input logic                 w_CLK,
    input logic                 RSTALLCARRYIN,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input logic                 wb_ack,
    input logic                 res_valid,
    input dsp_pkg::dsp_result_t res,
    input logic                 res_ready
);

    int assert_failures = 0;

    // Ack only answers an active strobe
    ack_needs_strobe: assert property (
        @(posedge w_CLK) disable iff (RSTALLCARRYIN)
        wb_ack |-> (wb_cyc && wb_stb)
    ) else begin
        assert_failures++;
        $error("wb_ack high without wb_cyc and wb_stb");
    end

    ack_single_cycle: assert property (
        @(posedge w_CLK) disable iff (RSTALLCARRYIN)
        wb_ack |=> !wb_ack
    ) else begin
        assert_failures++;
        $error("wb_ack high for two cycles in a row");
    end

    // Result is held while the outside stalls
    res_held: assert property (
        @(posedge w_CLK) disable iff (RSTALLCARRYIN)
        (res_valid && !res_ready) |=> (res_valid && $stable(res))
    ) else begin
        assert_failures++;
        $error("res changed or res_valid dropped before res_ready");
    end

    no_valid_after_reset: assert property (
        @(posedge w_CLK)
        RSTALLCARRYIN |=> !res_valid
    ) else begin
        assert_failures++;
        $error("res_valid high in the cycle after reset");
    end

endmodule

bind dsp_slice_top dsp_slice_checker u_checker (
    .w_CLK         (w_CLK),
    .RSTALLCARRYIN (RSTALLCARRYIN),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_ack        (wb_ack),
    .res_valid     (res_valid),
    .res           (res),
    .res_ready     (res_ready)
);

`default_nettype wire

// ==== verif/dsp_slice_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dsp_defs.svh"

module dsp_slice_tb;
    import dsp_pkg::*;

    localparam int ACK_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    logic        w_CLK;
    logic        RSTALLCARRYIN;
    logic        wb_cyc;
    logic        wb_stb;
    dsp_op_t     wb_op;
    logic        wb_ack;
    logic        res_valid;
    dsp_result_t res;
    logic        res_ready;

    // Reference model state kept in acceptance order
    logic [`DSP_P_W-1:0] model_p;
    logic                prev_pd;
    logic                prev_pbd;
    dsp_result_t         exp_q[$];
    string               name_q[$];

    int errors;
    int timeouts;
    int checker_fails;
    int ops_acked;
    int results_seen;
    int ovf_seen;
    int unf_seen;
    int ready_pct;
    bit stop_run;

    dsp_slice_top DUT (
        .w_CLK         (w_CLK),
        .RSTALLCARRYIN (RSTALLCARRYIN),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_op         (wb_op),
        .wb_ack        (wb_ack),
        .res_valid     (res_valid),
        .res           (res),
        .res_ready     (res_ready)
    );

    always #10 w_CLK = ~w_CLK;

    // Expected result of one operation and the model P and flags it leaves behind
    function automatic dsp_result_t model_step(input dsp_op_t op);
        logic signed [`DSP_MULT_A_W-1:0] ma;
        logic signed [`DSP_B_W-1:0]      mb;
        logic [`DSP_P_W-1:0]             x;
        logic [`DSP_P_W-1:0]             y;
        logic [`DSP_P_W-1:0]             z;
        logic [`DSP_P_W+1:0]             xyc;
        logic [`DSP_P_W+1:0]             total;
        dsp_result_t                     r;
        ma = op.a[`DSP_MULT_A_W-1:0];
        mb = op.b;
        case (op.ctrl.x_sel)
            X_MULT:  x = ma * mb;
            X_P:     x = model_p;
            X_AB:    x = {op.a, op.b};
            default: x = '0;
        endcase
        case (op.ctrl.y_sel)
            Y_C:     y = op.c;
            Y_ONES:  y = '1;
            default: y = '0;
        endcase
        case (op.ctrl.z_sel)
            Z_P:       z = model_p;
            Z_C:       z = op.c;
            // Sign fill from the top bit of P
            Z_P_SHIFT: z = {{`DSP_SHIFT{model_p[`DSP_P_W-1]}}, model_p[`DSP_P_W-1:`DSP_SHIFT]};
            default:   z = '0;
        endcase
        xyc = {2'b00, x} + {2'b00, y} + op.ctrl.carry_in;
        if (op.ctrl.alu_op == ALU_SUB) begin
            r.p         = z - xyc[`DSP_P_W-1:0];
            r.carry_out = ({2'b00, z} >= xyc);
        end else begin
            total       = xyc + {2'b00, z};
            r.p         = total[`DSP_P_W-1:0];
            r.carry_out = total[`DSP_P_W];
        end
        r.pattern_detect   = (r.p[47:46] == 2'b00);
        r.pattern_b_detect = (r.p[47:46] == 2'b11);
        r.overflow  = prev_pd & ~r.pattern_detect & ~r.pattern_b_detect;
        r.underflow = prev_pbd & ~r.pattern_detect & ~r.pattern_b_detect;
        model_p  = r.p;
        prev_pd  = r.pattern_detect;
        prev_pbd = r.pattern_b_detect;
        return r;
    endfunction

    // Random operation of a given kind; kind 5 picks one of kinds 0 to 3
    function automatic dsp_op_t make_op(input int kind, input int idx);
        dsp_op_t op;
        op.a = $urandom;
        op.b = $urandom;
        op.c = {$urandom, $urandom};
        op.ctrl = '{X_MULT, Y_ZERO, Z_ZERO, ALU_ADD, 1'b0};
        if (kind == 5) begin
            kind = $urandom_range(3, 0);
        end
        case (kind)
            1: begin
                op.ctrl.z_sel    = Z_P;
                op.ctrl.alu_op   = dsp_alu_op_e'($urandom_range(1, 0));
                op.ctrl.carry_in = $urandom_range(1, 0);
            end
            2: begin
                op.ctrl.x_sel    = dsp_x_sel_e'($urandom_range(3, 0));
                op.ctrl.y_sel    = dsp_y_sel_e'($urandom_range(2, 0));
                op.ctrl.z_sel    = dsp_z_sel_e'($urandom_range(2, 0));
                op.ctrl.alu_op   = dsp_alu_op_e'($urandom_range(1, 0));
                op.ctrl.carry_in = $urandom_range(1, 0);
            end
            3: begin
                op.ctrl.x_sel = $urandom_range(1, 0) ? X_AB : X_MULT;
                op.ctrl.y_sel = dsp_y_sel_e'($urandom_range(1, 0));
                op.ctrl.z_sel = Z_P_SHIFT;
            end
            4: begin
                // Clear P, then walk the top bits up by about 2^44 a step and back down
                op.ctrl.x_sel  = X_ZERO;
                op.ctrl.y_sel  = Y_C;
                op.ctrl.z_sel  = (idx == 0) ? Z_ZERO : Z_P;
                op.ctrl.alu_op = (idx > 24) ? ALU_SUB : ALU_ADD;
                op.c = (idx == 0) ? '0 : 48'h1000_0000_0000 + 48'($urandom_range(20'hFFFFF, 0));
            end
            default: ;
        endcase
        return op;
    endfunction

    // Called on a falling edge; returns on the falling edge after the capture
    task automatic issue_op(input dsp_op_t op, input string name);
        int waited;
        waited = 0;
        wb_op  = op;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        @(negedge w_CLK);
        while (!wb_ack && waited < ACK_TIMEOUT) begin
            @(negedge w_CLK);
            waited++;
        end
        if (!wb_ack) begin
            $display("Timeout: no Wishbone ack for %s after %0d cycles", name, waited);
            timeouts++;
            stop_run = 1'b1;
        end else begin
            exp_q.push_back(model_step(op));
            name_q.push_back(name);
            ops_acked++;
            @(negedge w_CLK);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic run_phase(input string name, input int kind, input int count,
                             input int max_gap);
        dsp_op_t op;
        for (int i = 0; i < count && !stop_run; i++) begin
            op = make_op(kind, i);
            issue_op(op, $sformatf("%s_%0d", name, i));
            repeat ($urandom_range(max_gap, 0)) @(negedge w_CLK);
        end
    endtask

    task automatic check_result();
        dsp_result_t exp;
        string       name;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("A result with p=%h came out with no accepted operation left", res.p);
        end
        if (exp_q.size() == 0) begin
            return;
        end
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
        results_seen++;
        ovf_seen += res.overflow;
        unf_seen += res.underflow;
        assert (res.p === exp.p) else begin
            errors++;
            $display("Error %s p: expected %h, actual %h", name, exp.p, res.p);
        end
        assert (res.carry_out === exp.carry_out) else begin
            errors++;
            $display("Error %s carry_out: expected %b, actual %b", name, exp.carry_out,
                     res.carry_out);
        end
        // Flags are pattern, pattern_b, overflow and underflow
        assert (res[3:0] === exp[3:0]) else begin
            errors++;
            $display("Error %s flags: expected %b, actual %b", name, exp[3:0], res[3:0]);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge w_CLK);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d results still missing after %0d cycles", exp_q.size(),
                     waited);
            timeouts++;
        end
    endtask

    // Random back-pressure on the result side with a compare at each handshake
    initial begin
        forever begin
            @(negedge w_CLK);
            res_ready = ($urandom_range(99, 0) < ready_pct);
            if (!RSTALLCARRYIN && res_valid && res_ready) begin
                check_result();
            end
        end
    end

    initial begin
        void'($urandom(32'h9823));
        w_CLK         = 1'b0;
        RSTALLCARRYIN = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_op         = '0;
        res_ready     = 1'b0;
        model_p       = '0;
        prev_pd       = 1'b0;
        prev_pbd      = 1'b0;
        errors        = 0;
        timeouts      = 0;
        checker_fails = 0;
        ops_acked     = 0;
        results_seen  = 0;
        ovf_seen      = 0;
        unf_seen      = 0;
        ready_pct     = 70;
        stop_run      = 1'b0;
        repeat (4) @(negedge w_CLK);
        RSTALLCARRYIN = 1'b0;

        run_phase("multiply", 0, 20, 2);
        run_phase("accumulate", 1, 30, 2);
        run_phase("operand_mix", 2, 30, 2);
        run_phase("p_shift", 3, 20, 2);
        run_phase("pattern_steer", 4, 49, 1);
        // Slow consumer with back-to-back writes fills the buffer
        ready_pct = 25;
        run_phase("backpressure", 5, 40, 0);
        ready_pct = 100;
        wait_drain();
        // A late duplicate would show up here
        repeat (10) @(negedge w_CLK);

        assert (results_seen == ops_acked) else begin
            errors++;
            $display("Error result_count: expected %0d, actual %0d", ops_acked, results_seen);
        end
        assert (ovf_seen > 0 && unf_seen > 0) else begin
            errors++;
            $display("Pattern steering did not produce both an overflow and an underflow");
        end
        checker_fails = DUT.u_checker.assert_failures;
        $display("Results %0d of %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 results_seen, ops_acked, errors, checker_fails, timeouts);
        if (errors == 0 && timeouts == 0 && checker_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
